// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int unsigned INSTR_WIDTH   = 32;
    localparam int unsigned DATA_WIDTH    = 32;
    localparam int unsigned GPR_NUM       = 32;
    localparam int unsigned ALU_OP_WIDTH  = 8;
    localparam int unsigned ALU_SEL_WIDTH = 3;

    typedef logic [INSTR_WIDTH-1:0]     instr_t;
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [$clog2(GPR_NUM)-1:0] reg_addr_t;
    typedef logic [ALU_OP_WIDTH-1:0]    aluop_t;
    typedef logic [ALU_SEL_WIDTH-1:0]   alusel_t;

    // Opcode fields at instr[31:15] and instr[31:22]
    typedef logic [16:0] opc_3r_t;
    typedef logic [9:0]  opc_2ri12_t;

    // ALU operations
    localparam aluop_t NOP_OP     = 8'h00;
    localparam aluop_t ADD_OP     = 8'h01;
    localparam aluop_t SUB_OP     = 8'h02;
    localparam aluop_t SLT_OP     = 8'h03;
    localparam aluop_t SLTU_OP    = 8'h04;
    localparam aluop_t NOR_OP     = 8'h08;
    localparam aluop_t AND_OP     = 8'h09;
    localparam aluop_t OR_OP      = 8'h0a;
    localparam aluop_t XOR_OP     = 8'h0b;
    localparam aluop_t ORN_OP     = 8'h0c;
    localparam aluop_t ANDN_OP    = 8'h0d;
    localparam aluop_t SLL_OP     = 8'h10;
    localparam aluop_t SRL_OP     = 8'h11;
    localparam aluop_t SRA_OP     = 8'h12;
    localparam aluop_t MUL_OP     = 8'h18;
    localparam aluop_t MULH_OP    = 8'h19;
    localparam aluop_t MULHU_OP   = 8'h1a;
    localparam aluop_t DIV_OP     = 8'h20;
    localparam aluop_t DIVU_OP    = 8'h21;
    localparam aluop_t MOD_OP     = 8'h22;
    localparam aluop_t MODU_OP    = 8'h23;
    localparam aluop_t BREAK_OP   = 8'h30;
    localparam aluop_t SYSCALL_OP = 8'h31;
    localparam aluop_t IDLE_OP    = 8'h32;
    localparam aluop_t INVTLB_OP  = 8'h33;

    // Result group selectors
    localparam alusel_t RES_NOP   = 3'd0;
    localparam alusel_t RES_LOGIC = 3'd1;
    localparam alusel_t RES_SHIFT = 3'd2;
    localparam alusel_t RES_ARITH = 3'd3;

    // 3R opcodes
    localparam opc_3r_t OPC_ADD_W   = 17'h00020;
    localparam opc_3r_t OPC_SUB_W   = 17'h00022;
    localparam opc_3r_t OPC_SLT     = 17'h00024;
    localparam opc_3r_t OPC_SLTU    = 17'h00025;
    localparam opc_3r_t OPC_NOR     = 17'h00028;
    localparam opc_3r_t OPC_AND     = 17'h00029;
    localparam opc_3r_t OPC_OR      = 17'h0002a;
    localparam opc_3r_t OPC_XOR     = 17'h0002b;
    localparam opc_3r_t OPC_ORN     = 17'h0002c;
    localparam opc_3r_t OPC_ANDN    = 17'h0002d;
    localparam opc_3r_t OPC_SLL_W   = 17'h0002e;
    localparam opc_3r_t OPC_SRL_W   = 17'h0002f;
    localparam opc_3r_t OPC_SRA_W   = 17'h00030;
    localparam opc_3r_t OPC_MUL_W   = 17'h00038;
    localparam opc_3r_t OPC_MULH_W  = 17'h00039;
    localparam opc_3r_t OPC_MULH_WU = 17'h0003a;
    localparam opc_3r_t OPC_DIV_W   = 17'h00040;
    localparam opc_3r_t OPC_MOD_W   = 17'h00041;
    localparam opc_3r_t OPC_DIV_WU  = 17'h00042;
    localparam opc_3r_t OPC_MOD_WU  = 17'h00043;
    localparam opc_3r_t OPC_BREAK   = 17'h00054;
    localparam opc_3r_t OPC_SYSCALL = 17'h00056;
    localparam opc_3r_t OPC_IDLE    = 17'h00c91;
    localparam opc_3r_t OPC_INVTLB  = 17'h00c93;
    localparam opc_3r_t OPC_DBAR    = 17'h070e4;
    localparam opc_3r_t OPC_IBAR    = 17'h070e5;

    // 2RI12 opcodes
    localparam opc_2ri12_t OPC_SLTI   = 10'h008;
    localparam opc_2ri12_t OPC_SLTUI  = 10'h009;
    localparam opc_2ri12_t OPC_ADDI_W = 10'h00a;
    localparam opc_2ri12_t OPC_ANDI   = 10'h00d;
    localparam opc_2ri12_t OPC_ORI    = 10'h00e;
    localparam opc_2ri12_t OPC_XORI   = 10'h00f;

    typedef struct packed {
        logic redirect;
        logic is_pri;
        logic not_commit_instr;
        logic need_refetch;
    } special_info_t;

    // Flags shared by break, syscall and idle
    localparam special_info_t TRAP_SPECIAL = '{
        redirect:         1'b1,
        is_pri:           1'b1,
        not_commit_instr: 1'b1,
        need_refetch:     1'b0
    };

    typedef struct packed {
        logic            hit;
        logic [1:0]      reg_read_valid;   // {rj, rk}
        reg_addr_t [1:0] reg_read_addr;    // {rk, rj}
        logic            reg_write_valid;
        reg_addr_t       reg_write_addr;
        logic            use_imm;
        data_t           imm;
        aluop_t          aluop;
        alusel_t         alusel;
        logic            is_break;
        logic            is_syscall;
        special_info_t   special;
    } decode_info_t;

endpackage

`default_nettype wire

// File: decoder_3r.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_3r (
    input  decode_pkg::instr_t       instr_i,
    output decode_pkg::decode_info_t info_o
);

    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t rj;
    decode_pkg::reg_addr_t rk;
    decode_pkg::opc_3r_t   opcode;

    // Register use of the matched instruction
    logic read_rr;
    logic write_rd;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign rk     = instr_i[14:10];
    assign opcode = instr_i[31:15];

    always_comb begin
        info_o     = '0;
        info_o.hit = 1'b1;
        read_rr    = 1'b1;
        write_rd   = 1'b1;
        case (opcode)
            decode_pkg::OPC_ADD_W,
            decode_pkg::OPC_SUB_W,
            decode_pkg::OPC_SLT,
            decode_pkg::OPC_SLTU,
            decode_pkg::OPC_MUL_W,
            decode_pkg::OPC_MULH_W,
            decode_pkg::OPC_MULH_WU,
            decode_pkg::OPC_DIV_W,
            decode_pkg::OPC_DIV_WU,
            decode_pkg::OPC_MOD_W,
            decode_pkg::OPC_MOD_WU: begin
                info_o.alusel = decode_pkg::RES_ARITH;
            end
            decode_pkg::OPC_NOR,
            decode_pkg::OPC_AND,
            decode_pkg::OPC_OR,
            decode_pkg::OPC_XOR,
            decode_pkg::OPC_ORN,
            decode_pkg::OPC_ANDN: begin
                info_o.alusel = decode_pkg::RES_LOGIC;
            end
            decode_pkg::OPC_SLL_W,
            decode_pkg::OPC_SRL_W,
            decode_pkg::OPC_SRA_W: begin
                info_o.alusel = decode_pkg::RES_SHIFT;
            end
            decode_pkg::OPC_BREAK: begin
                info_o.aluop    = decode_pkg::BREAK_OP;
                info_o.is_break = 1'b1;
                info_o.special  = decode_pkg::TRAP_SPECIAL;
                read_rr         = 1'b0;
                write_rd        = 1'b0;
            end
            decode_pkg::OPC_SYSCALL: begin
                info_o.aluop      = decode_pkg::SYSCALL_OP;
                info_o.is_syscall = 1'b1;
                info_o.special    = decode_pkg::TRAP_SPECIAL;
                read_rr           = 1'b0;
                write_rd          = 1'b0;
            end
            decode_pkg::OPC_IDLE: begin
                info_o.aluop   = decode_pkg::IDLE_OP;
                info_o.special = decode_pkg::TRAP_SPECIAL;
            end
            decode_pkg::OPC_DBAR,
            decode_pkg::OPC_IBAR: begin
                read_rr  = 1'b0;
                write_rd = 1'b0;
            end
            decode_pkg::OPC_INVTLB: begin
                // instr[4:0] is the invalidate op, not rd
                info_o.aluop                = decode_pkg::INVTLB_OP;
                info_o.imm                  = decode_pkg::data_t'(instr_i[4:0]);
                info_o.special.is_pri       = 1'b1;
                info_o.special.need_refetch = 1'b1;
                write_rd                    = 1'b0;
            end
            default: begin
                info_o.hit = 1'b0;
                read_rr    = 1'b0;
                write_rd   = 1'b0;
            end
        endcase

        // ALU op for the plain register-form groups
        case (opcode)
            decode_pkg::OPC_ADD_W:   info_o.aluop = decode_pkg::ADD_OP;
            decode_pkg::OPC_SUB_W:   info_o.aluop = decode_pkg::SUB_OP;
            decode_pkg::OPC_SLT:     info_o.aluop = decode_pkg::SLT_OP;
            decode_pkg::OPC_SLTU:    info_o.aluop = decode_pkg::SLTU_OP;
            decode_pkg::OPC_NOR:     info_o.aluop = decode_pkg::NOR_OP;
            decode_pkg::OPC_AND:     info_o.aluop = decode_pkg::AND_OP;
            decode_pkg::OPC_OR:      info_o.aluop = decode_pkg::OR_OP;
            decode_pkg::OPC_XOR:     info_o.aluop = decode_pkg::XOR_OP;
            decode_pkg::OPC_ORN:     info_o.aluop = decode_pkg::ORN_OP;
            decode_pkg::OPC_ANDN:    info_o.aluop = decode_pkg::ANDN_OP;
            decode_pkg::OPC_SLL_W:   info_o.aluop = decode_pkg::SLL_OP;
            decode_pkg::OPC_SRL_W:   info_o.aluop = decode_pkg::SRL_OP;
            decode_pkg::OPC_SRA_W:   info_o.aluop = decode_pkg::SRA_OP;
            decode_pkg::OPC_MUL_W:   info_o.aluop = decode_pkg::MUL_OP;
            decode_pkg::OPC_MULH_W:  info_o.aluop = decode_pkg::MULH_OP;
            decode_pkg::OPC_MULH_WU: info_o.aluop = decode_pkg::MULHU_OP;
            decode_pkg::OPC_DIV_W:   info_o.aluop = decode_pkg::DIV_OP;
            decode_pkg::OPC_DIV_WU:  info_o.aluop = decode_pkg::DIVU_OP;
            decode_pkg::OPC_MOD_W:   info_o.aluop = decode_pkg::MOD_OP;
            decode_pkg::OPC_MOD_WU:  info_o.aluop = decode_pkg::MODU_OP;
            default: ;
        endcase

        if (read_rr) begin
            info_o.reg_read_valid = 2'b11;
            info_o.reg_read_addr  = {rk, rj};
        end
        if (write_rd) begin
            info_o.reg_write_valid = 1'b1;
            info_o.reg_write_addr  = rd;
        end
    end

endmodule

`default_nettype wire

// File: decoder_2ri12.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_2ri12 (
    input  decode_pkg::instr_t       instr_i,
    output decode_pkg::decode_info_t info_o
);

    decode_pkg::reg_addr_t  rd;
    decode_pkg::reg_addr_t  rj;
    decode_pkg::opc_2ri12_t opcode;
    logic [11:0]            imm12;

    // Logic ops take an unsigned immediate
    logic sign_ext;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign imm12  = instr_i[21:10];
    assign opcode = instr_i[31:22];

    always_comb begin
        info_o     = '0;
        info_o.hit = 1'b1;
        sign_ext   = 1'b1;
        case (opcode)
            decode_pkg::OPC_ADDI_W: begin
                info_o.aluop  = decode_pkg::ADD_OP;
                info_o.alusel = decode_pkg::RES_ARITH;
            end
            decode_pkg::OPC_SLTI: begin
                info_o.aluop  = decode_pkg::SLT_OP;
                info_o.alusel = decode_pkg::RES_ARITH;
            end
            decode_pkg::OPC_SLTUI: begin
                info_o.aluop  = decode_pkg::SLTU_OP;
                info_o.alusel = decode_pkg::RES_ARITH;
            end
            decode_pkg::OPC_ANDI: begin
                info_o.aluop  = decode_pkg::AND_OP;
                info_o.alusel = decode_pkg::RES_LOGIC;
                sign_ext      = 1'b0;
            end
            decode_pkg::OPC_ORI: begin
                info_o.aluop  = decode_pkg::OR_OP;
                info_o.alusel = decode_pkg::RES_LOGIC;
                sign_ext      = 1'b0;
            end
            decode_pkg::OPC_XORI: begin
                info_o.aluop  = decode_pkg::XOR_OP;
                info_o.alusel = decode_pkg::RES_LOGIC;
                sign_ext      = 1'b0;
            end
            default: begin
                info_o.hit = 1'b0;
            end
        endcase

        if (info_o.hit) begin
            // Only rj is read and the rk slot stays zero
            info_o.reg_read_valid   = 2'b10;
            info_o.reg_read_addr[0] = rj;
            info_o.reg_write_valid  = 1'b1;
            info_o.reg_write_addr   = rd;
            info_o.use_imm          = 1'b1;
            if (sign_ext) begin
                info_o.imm = {{(decode_pkg::DATA_WIDTH-12){imm12[11]}}, imm12};
            end else begin
                info_o.imm = {{(decode_pkg::DATA_WIDTH-12){1'b0}}, imm12};
            end
        end
    end

endmodule

`default_nettype wire

// File: decode_select.sv
`timescale 1ns/1ps
`default_nettype none

module decode_select (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     instr_valid_i,
    input  decode_pkg::decode_info_t info_3r_i,
    input  decode_pkg::decode_info_t info_2ri12_i,
    output logic                     dec_valid_o,
    output decode_pkg::decode_info_t dec_o,
    output logic                     illegal_o
);

    decode_pkg::decode_info_t sel_info;
    logic                     any_hit;

    assign any_hit = info_3r_i.hit | info_2ri12_i.hit;

    // 3R wins if both ever claim the word
    always_comb begin
        if (info_3r_i.hit) begin
            sel_info = info_3r_i;
        end else if (info_2ri12_i.hit) begin
            sel_info = info_2ri12_i;
        end else begin
            sel_info = '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
            dec_o       <= '0;
        end else begin
            dec_valid_o <= instr_valid_i;
            illegal_o   <= instr_valid_i & ~any_hit;
            if (instr_valid_i) begin
                dec_o <= sel_info;
            end
        end
    end

    // Opcode tables of the two decoders are disjoint
    a_no_dual_hit: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(info_3r_i.hit && info_2ri12_i.hit)
    );

    // One record out per strobe one cycle later
    a_valid_latency: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dec_valid_o == $past(instr_valid_i)
    );

    a_illegal_no_hit: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        illegal_o |-> (dec_valid_o && !dec_o.hit)
    );

endmodule

`default_nettype wire

// File: id_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_unit (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     instr_valid_i,
    input  decode_pkg::instr_t       instr_i,
    output logic                     dec_valid_o,
    output decode_pkg::decode_info_t dec_o,
    output logic                     illegal_o
);

    decode_pkg::decode_info_t info_3r;
    decode_pkg::decode_info_t info_2ri12;

    decoder_3r u_decoder_3r (
        .instr_i (instr_i),
        .info_o  (info_3r)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_i (instr_i),
        .info_o  (info_2ri12)
    );

    // Merge and register
    decode_select u_decode_select (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .info_3r_i     (info_3r),
        .info_2ri12_i  (info_2ri12),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o),
        .illegal_o     (illegal_o)
    );

endmodule

`default_nettype wire

// File: tb_id_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_unit;

    logic                     clk_i = 1'b0;
    logic                     arst_n_i;
    logic                     instr_valid_i;
    decode_pkg::instr_t       instr_i;
    logic                     dec_valid_o;
    decode_pkg::decode_info_t dec_o;
    logic                     illegal_o;

    decode_pkg::instr_t       vec_instr[$];
    decode_pkg::decode_info_t vec_exp[$];
    logic                     vec_illegal[$];
    int                       vec_count;
    logic                     vectors_loaded;
    integer                   seed;

    id_unit u_id_unit (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o),
        .illegal_o     (illegal_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("error: time %0.1f ns, %s expected %0h, actual %0h",
                     $realtime, name, exp, act);
            stop_with_failure("decoded output mismatch");
        end
    endtask

    task automatic check_outputs(input logic exp_valid, input logic exp_illegal,
                                 input decode_pkg::decode_info_t exp);
        check_value("dec_valid_o", 32'(exp_valid), 32'(dec_valid_o));
        check_value("illegal_o", 32'(exp_illegal), 32'(illegal_o));
        check_value("dec_o.hit", 32'(exp.hit), 32'(dec_o.hit));
        check_value("dec_o.reg_read_valid", 32'(exp.reg_read_valid), 32'(dec_o.reg_read_valid));
        check_value("dec_o.reg_read_addr", 32'(exp.reg_read_addr), 32'(dec_o.reg_read_addr));
        check_value("dec_o.reg_write_valid", 32'(exp.reg_write_valid),
                    32'(dec_o.reg_write_valid));
        check_value("dec_o.reg_write_addr", 32'(exp.reg_write_addr), 32'(dec_o.reg_write_addr));
        check_value("dec_o.use_imm", 32'(exp.use_imm), 32'(dec_o.use_imm));
        check_value("dec_o.imm", exp.imm, dec_o.imm);
        check_value("dec_o.aluop", 32'(exp.aluop), 32'(dec_o.aluop));
        check_value("dec_o.alusel", 32'(exp.alusel), 32'(dec_o.alusel));
        check_value("dec_o.is_break", 32'(exp.is_break), 32'(dec_o.is_break));
        check_value("dec_o.is_syscall", 32'(exp.is_syscall), 32'(dec_o.is_syscall));
        check_value("dec_o.special", 32'(exp.special), 32'(dec_o.special));
    endtask

    task automatic load_vectors();
        integer                   fd;
        integer                   code;
        logic                     done;
        logic [31:0]              f_instr;
        logic [31:0]              f_hit;
        logic [31:0]              f_rd_valid;
        logic [31:0]              f_rd_addr;
        logic [31:0]              f_wr_valid;
        logic [31:0]              f_wr_addr;
        logic [31:0]              f_use_imm;
        logic [31:0]              f_imm;
        logic [31:0]              f_aluop;
        logic [31:0]              f_alusel;
        logic [31:0]              f_break;
        logic [31:0]              f_syscall;
        logic [31:0]              f_special;
        logic [31:0]              f_illegal;
        decode_pkg::decode_info_t rec;
        fd = $fopen("id_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open id_vectors.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                           f_instr, f_hit, f_rd_valid, f_rd_addr, f_wr_valid, f_wr_addr,
                           f_use_imm, f_imm, f_aluop, f_alusel, f_break, f_syscall,
                           f_special, f_illegal);
            // Word plus thirteen expected columns
            if (code == 14) begin
                rec                 = '0;
                rec.hit             = f_hit[0];
                rec.reg_read_valid  = f_rd_valid[1:0];
                rec.reg_read_addr   = f_rd_addr[9:0];
                rec.reg_write_valid = f_wr_valid[0];
                rec.reg_write_addr  = f_wr_addr[4:0];
                rec.use_imm         = f_use_imm[0];
                rec.imm             = f_imm;
                rec.aluop           = f_aluop[7:0];
                rec.alusel          = f_alusel[2:0];
                rec.is_break        = f_break[0];
                rec.is_syscall      = f_syscall[0];
                rec.special         = f_special[3:0];
                vec_instr.push_back(f_instr);
                vec_exp.push_back(rec);
                vec_illegal.push_back(f_illegal[0]);
            end else if (code <= 0 && $feof(fd)) begin
                done = 1'b1;
            end else begin
                stop_with_failure("malformed line in id_vectors.txt");
            end
        end
        $fclose(fd);
        vec_count = vec_instr.size();
        if (vec_count == 0) begin
            stop_with_failure("id_vectors.txt holds no vectors");
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #0.5;
    endtask

    initial begin
        decode_pkg::decode_info_t exp_rec;
        logic                     exp_valid;
        logic                     exp_illegal;
        int                       gap;
        int                       back_to_back;
        int                       idle_cycles;
        seed           = 32'h65eac1a5;
        arst_n_i       = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        vectors_loaded = 1'b0;
        vec_count      = 0;
        back_to_back   = 0;
        idle_cycles    = 0;
        load_vectors();

        repeat (5) @(posedge clk_i);
        #0.5;
        // Outputs cleared while reset is held
        check_outputs(1'b0, 1'b0, '0);
        arst_n_i    = 1'b1;
        exp_valid   = 1'b0;
        exp_illegal = 1'b0;
        exp_rec     = '0;

        for (int i = 0; i < vec_count; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                next_cycle();
                check_outputs(exp_valid, exp_illegal, exp_rec);
                // Random word without a strobe so the record holds
                instr_valid_i = 1'b0;
                instr_i       = $random(seed);
                exp_valid     = 1'b0;
                exp_illegal   = 1'b0;
                idle_cycles   = idle_cycles + 1;
            end
            next_cycle();
            check_outputs(exp_valid, exp_illegal, exp_rec);
            if (exp_valid) begin
                back_to_back = back_to_back + 1;
            end
            instr_valid_i = 1'b1;
            instr_i       = vec_instr[i];
            exp_valid     = 1'b1;
            exp_illegal   = vec_illegal[i];
            exp_rec       = vec_exp[i];
        end

        // Drain the last record
        next_cycle();
        check_outputs(exp_valid, exp_illegal, exp_rec);
        instr_valid_i = 1'b0;
        exp_valid     = 1'b0;
        exp_illegal   = 1'b0;
        next_cycle();
        check_outputs(exp_valid, exp_illegal, exp_rec);

        if (back_to_back == 0 || idle_cycles == 0) begin
            stop_with_failure("strobe pattern never had both back-to-back strobes and gaps");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // Watchdog sized from the vector count
    initial begin
        wait (vectors_loaded === 1'b1);
        repeat (vec_count * 5 + 100) @(posedge clk_i);
        stop_with_failure($sformatf("timeout: test did not finish within %0d cycles",
                                    vec_count * 5 + 100));
    end

endmodule

`default_nettype wire

// File: id_vectors.txt
00100C41 1 3 062 1 01 0 00000000 01 3 0 0 0 0
001118A4 1 3 0C5 1 04 0 00000000 02 3 0 0 0 0
001277DF 1 3 3BE 1 1F 0 00000000 03 3 0 0 0 0
0012AA20 1 3 151 1 00 0 00000000 04 3 0 0 0 0
00144CEC 1 3 267 1 0C 0 00000000 08 1 0 0 0 0
00148C41 1 3 062 1 01 0 00000000 09 1 0 0 0 0
001518A4 1 3 0C5 1 04 0 00000000 0A 1 0 0 0 0
0015F7DF 1 3 3BE 1 1F 0 00000000 0B 1 0 0 0 0
00162A20 1 3 151 1 00 0 00000000 0C 1 0 0 0 0
0016CCEC 1 3 267 1 0C 0 00000000 0D 1 0 0 0 0
00170C41 1 3 062 1 01 0 00000000 10 2 0 0 0 0
001798A4 1 3 0C5 1 04 0 00000000 11 2 0 0 0 0
001877DF 1 3 3BE 1 1F 0 00000000 12 2 0 0 0 0
001C2A20 1 3 151 1 00 0 00000000 18 3 0 0 0 0
001CCCEC 1 3 267 1 0C 0 00000000 19 3 0 0 0 0
001D0C41 1 3 062 1 01 0 00000000 1A 3 0 0 0 0
002018A4 1 3 0C5 1 04 0 00000000 20 3 0 0 0 0
0020F7DF 1 3 3BE 1 1F 0 00000000 22 3 0 0 0 0
00212A20 1 3 151 1 00 0 00000000 21 3 0 0 0 0
0021CCEC 1 3 267 1 0C 0 00000000 23 3 0 0 0 0
002A0005 1 0 000 0 00 0 00000000 30 0 1 0 E 0
002B0011 1 0 000 0 00 0 00000000 31 0 0 1 E 0
06488C41 1 3 062 1 01 0 00000000 32 0 0 0 E 0
38720000 1 0 000 0 00 0 00000000 00 0 0 0 0 0
38728000 1 0 000 0 00 0 00000000 00 0 0 0 0 0
064998A4 1 3 0C5 0 00 0 00000004 33 0 0 0 5 0
0649F7DF 1 3 3BE 0 00 0 0000001F 33 0 0 0 5 0
029FFC41 1 2 002 1 01 1 000007FF 01 3 0 0 0 0
02BFFC83 1 2 004 1 03 1 FFFFFFFF 01 3 0 0 0 0
028007E0 1 2 01F 1 00 1 00000001 01 3 0 0 0 0
022000C5 1 2 006 1 05 1 FFFFF800 03 3 0 0 0 0
027C0107 1 2 008 1 07 1 FFFFFF00 04 3 0 0 0 0
02448D49 1 2 00A 1 09 1 00000123 04 3 0 0 0 0
037FFD8B 1 2 00C 1 0B 1 00000FFF 09 1 0 0 0 0
03A001CD 1 2 00E 1 0D 1 00000800 0A 1 0 0 0 0
03E96A0F 1 2 010 1 0F 1 00000A5A 0B 1 0 0 0 0
00000000 0 0 000 0 00 0 00000000 00 0 0 0 0 1
FFFFFFFF 0 0 000 0 00 0 00000000 00 0 0 0 0 1
00108000 0 0 000 0 00 0 00000000 00 0 0 0 0 1
02C00000 0 0 000 0 00 0 00000000 00 0 0 0 0 1
28800000 0 0 000 0 00 0 00000000 00 0 0 0 0 1
4C000020 0 0 000 0 00 0 00000000 00 0 0 0 0 1

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the decode testbench with Verilator
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_unit -Mdir "${OBJ_DIR}" -f src.f

# Result is judged from the log
"./${OBJ_DIR}/Vtb_id_unit" 2>&1 | tee "${LOG_FILE}"

if grep -q "SIMULATION FAILED" "${LOG_FILE}"; then
    echo "Decode test failed, see ${LOG_FILE}"
    exit 1
fi

echo "Decode test passed, log in ${LOG_FILE}"

// File: src.f
decode_pkg.sv
decoder_3r.sv
decoder_2ri12.sv
decode_select.sv
id_unit.sv
tb_id_unit.sv
